// File: Bender.yml
package:
  name: int_isq

sources:
  - isq_pkg.sv
  - iq_entry.sv
  - age_select.sv
  - int_isq.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_int_isq.sv

// File: age_select.sv
`timescale 1ns/1ps

module age_select import isq_pkg::*; (
    input  logic                clock,
    input  logic                rst,
    input  logic [IQ_DEPTH-1:0] alloc_oh,
    input  logic [IQ_DEPTH-1:0] valid,
    input  logic [IQ_DEPTH-1:0] ready,
    output logic [IQ_DEPTH-1:0] oldest_oh
);

    // older_q[i][j] set means slot j entered the queue before slot i
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older_q;
    logic [IQ_DEPTH-1:0][IQ_DEPTH-1:0] older_d;

    always_comb begin
        older_d = older_q;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            for (int j = 0; j < IQ_DEPTH; j++) begin
                if (alloc_oh[i]) begin
                    // the new slot is younger than everything already held
                    older_d[i][j] = valid[j];
                end else if (alloc_oh[j]) begin
                    // and nobody treats the new slot as older than itself
                    older_d[i][j] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            older_q <= '0;
        end else if (|alloc_oh) begin
            older_q <= older_d;
        end
    end

    // stale bits left by freed slots are masked because a freed slot is never ready
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            oldest_oh[i] = ready[i] & ~(|(older_q[i] & ready));
        end
    end

endmodule

// File: flist.f
isq_pkg.sv
iq_entry.sv
age_select.sv
int_isq.sv
tb_clock_gen.sv
tb_int_isq.sv

// File: int_isq.sv
`timescale 1ns/1ps

module int_isq import isq_pkg::*; (
    input  logic                clock,
    input  logic                rst,
    input  logic                enq_valid,
    input  enq_t                enq,
    output logic                iq_can_alloc,
    input  wb_t  [WB_PORTS-1:0] wb,
    output logic                issue_valid,
    input  logic                issue_ready,
    output uop_t                issue_uop,
    input  logic                flush_valid,
    input  logic [ROB_ID_W-1:0] flush_robid
);

    logic [IQ_DEPTH-1:0] slot_valid;
    logic [IQ_DEPTH-1:0] slot_ready;
    logic [IQ_DEPTH-1:0] free_oh;
    logic [IQ_DEPTH-1:0] alloc_oh;
    logic [IQ_DEPTH-1:0] oldest_oh;
    logic [IQ_DEPTH-1:0] issuing;
    uop_t                slot_uop [IQ_DEPTH];

    logic [IQ_IDX_W-1:0] free_idx;
    logic                free_found;
    logic                enq_fire;
    logic                issue_fire;

    // lowest numbered empty slot, scanned from the top so slot 0 wins
    always_comb begin
        free_idx   = '0;
        free_found = 1'b0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid[i]) begin
                free_idx   = IQ_IDX_W'(i);
                free_found = 1'b1;
            end
        end
    end

    assign free_oh = IQ_DEPTH'(1) << free_idx;

    // a flush cycle takes nothing new in
    assign iq_can_alloc = free_found & ~flush_valid;
    assign enq_fire     = enq_valid & iq_can_alloc;
    assign alloc_oh     = enq_fire ? free_oh : '0;

    age_select u_age_select (
        .clock     (clock),
        .rst       (rst),
        .alloc_oh  (alloc_oh),
        .valid     (slot_valid),
        .ready     (slot_ready),
        .oldest_oh (oldest_oh)
    );

    // issue is held off while the ROB is flushing
    assign issue_valid = (|oldest_oh) & ~flush_valid;
    assign issue_fire  = issue_valid & issue_ready;
    assign issuing     = issue_fire ? oldest_oh : '0;

    // and-or mux over the one-hot pick
    always_comb begin
        issue_uop = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (oldest_oh[i]) begin
                issue_uop = issue_uop | slot_uop[i];
            end
        end
    end

    for (genvar g = 0; g < IQ_DEPTH; g++) begin : g_slot
        iq_entry u_iq_entry (
            .clock       (clock),
            .rst         (rst),
            .alloc       (alloc_oh[g]),
            .enq         (enq),
            .wb          (wb),
            .issuing     (issuing[g]),
            .flush_valid (flush_valid),
            .flush_robid (flush_robid),
            .valid       (slot_valid[g]),
            .ready       (slot_ready[g]),
            .uop         (slot_uop[g])
        );
    end

endmodule

// File: iq_entry.sv
`timescale 1ns/1ps

module iq_entry import isq_pkg::*; (
    input  logic                      clock,
    input  logic                      rst,
    input  logic                      alloc,
    input  enq_t                      enq,
    input  wb_t  [WB_PORTS-1:0]       wb,
    input  logic                      issuing,
    input  logic                      flush_valid,
    input  logic [ROB_ID_W-1:0]       flush_robid,
    output logic                      valid,
    output logic                      ready,
    output uop_t                      uop
);

    logic src1_rdy;
    logic src2_rdy;
    logic enq_hit1;
    logic enq_hit2;
    logic hold_hit1;
    logic hold_hit2;
    logic younger;

    // true when any result bus carries the tag of a register source
    function automatic logic wb_match(
        input wb_t [WB_PORTS-1:0] bus,
        input logic [PREG_W-1:0]  tag,
        input logic               is_reg
    );
        logic hit;
        hit = 1'b0;
        for (int p = 0; p < WB_PORTS; p++) begin
            if (bus[p].valid && bus[p].need_to_wb && (bus[p].prd == tag)) begin
                hit = 1'b1;
            end
        end
        return hit & is_reg;
    endfunction

    // a result in the dispatch cycle is compared against the incoming tags
    assign enq_hit1 = wb_match(wb, enq.uop.prs1, enq.uop.src1_is_reg);
    assign enq_hit2 = wb_match(wb, enq.uop.prs2, enq.uop.src2_is_reg);

    assign hold_hit1 = wb_match(wb, uop.prs1, uop.src1_is_reg);
    assign hold_hit2 = wb_match(wb, uop.prs2, uop.src2_is_reg);

    // same wrap bit means plain compare, different wrap means the order flips
    always_comb begin
        if (uop.robid[ROB_ID_W-1] == flush_robid[ROB_ID_W-1]) begin
            younger = uop.robid[ROB_ID_W-2:0] > flush_robid[ROB_ID_W-2:0];
        end else begin
            younger = uop.robid[ROB_ID_W-2:0] < flush_robid[ROB_ID_W-2:0];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            valid    <= 1'b0;
            src1_rdy <= 1'b0;
            src2_rdy <= 1'b0;
        end else if (alloc) begin
            valid    <= 1'b1;
            src1_rdy <= enq.src1_state | enq_hit1;
            src2_rdy <= enq.src2_state | enq_hit2;
        end else if (issuing || (flush_valid && younger)) begin
            valid <= 1'b0;
        end else if (valid) begin
            src1_rdy <= src1_rdy | hold_hit1;
            src2_rdy <= src2_rdy | hold_hit2;
        end
    end

    // payload is only meaningful while valid is set
    always_ff @(posedge clock) begin
        if (alloc) begin
            uop <= enq.uop;
        end
    end

    assign ready = valid & src1_rdy & src2_rdy;

endmodule

// File: isq_pkg.sv
package isq_pkg;

    // queue geometry
    localparam int IQ_DEPTH = 8;
    localparam int IQ_IDX_W = 3;

    // datapath widths
    localparam int PREG_W     = 6;
    localparam int ROB_ID_W   = 6;
    localparam int PC_W       = 32;
    localparam int XLEN       = 64;
    localparam int ALU_TYPE_W = 4;

    // number of result buses that can wake up sources each cycle
    localparam int WB_PORTS = 2;

    // one result broadcast from the execute stage
    typedef struct packed {
        logic              valid;
        logic              need_to_wb;
        logic [PREG_W-1:0] prd;
    } wb_t;

    // renamed micro-op as it sits in the queue and leaves on issue
    typedef struct packed {
        logic [PC_W-1:0]       pc;
        logic [31:0]           instr;
        logic [XLEN-1:0]       imm;
        logic [ALU_TYPE_W-1:0] alu_type;
        logic                  is_imm;
        logic                  is_load;
        logic                  is_store;
        logic                  need_to_wb;
        logic                  src1_is_reg;
        logic                  src2_is_reg;
        logic [PREG_W-1:0]     prs1;
        logic [PREG_W-1:0]     prs2;
        logic [PREG_W-1:0]     prd;
        // top bit is the wrap bit
        logic [ROB_ID_W-1:0]   robid;
    } uop_t;

    // dispatch request, the micro-op plus source readiness seen at rename
    typedef struct packed {
        uop_t uop;
        logic src1_state;
        logic src2_state;
    } enq_t;

endpackage

// File: isq_trace.txt
# ev rob prs1 prs2 prd r1 r2 s1 s2 | wb0 v n tag | wb1 v n tag | flush v robid | issue_ready
# then expected can_alloc issue_valid robid prd; one cycle per line, all hex
# ordering, slot 0 is reused so age order differs from slot order
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  0  1 0 00 00
1 01 00 00 11 0 0 1 1  0 0 00  0 0 00  0 00  0  1 0 00 00
1 02 00 00 12 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 01 11
1 03 00 00 13 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 01 11
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 01 11
1 04 00 00 14 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 02 12
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 02 12
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 03 13
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 04 14
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 0 00 00
# wakeup on both ports, same cycle wakeup, an older entry takes over, flush at 1c
1 1a 20 21 30 1 1 0 0  0 0 00  0 0 00  0 00  1  1 0 00 00
1 1b 23 00 31 1 0 0 1  1 0 20  1 1 23  0 00  1  1 0 00 00
1 1c 00 00 32 0 0 1 1  1 1 20  0 0 00  0 00  0  1 1 1b 31
1 1d 24 00 33 0 0 0 1  1 1 24  1 1 21  0 00  0  1 1 1b 31
0 00 00 00 00 0 0 0 0  1 1 24  0 0 00  0 00  0  1 1 1a 30
1 20 00 00 34 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 1a 30
1 21 00 00 35 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 1a 30
1 22 00 00 3f 0 0 1 1  0 0 00  0 0 00  1 1c  1  0 0 00 00
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 1a 30
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 1b 31
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 1c 32
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 0 00 00
# flush at 20 keeps the older ids from before the wrap
1 1e 25 00 36 1 0 0 1  0 0 00  0 0 00  0 00  1  1 0 00 00
1 1f 00 00 37 0 0 1 1  0 0 00  0 0 00  0 00  0  1 0 00 00
1 20 00 00 38 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 1f 37
1 21 00 00 39 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 1f 37
1 22 00 00 3a 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 1f 37
0 00 00 00 00 0 0 0 0  1 1 25  0 0 00  1 20  1  0 0 00 00
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 1e 36
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 1f 37
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 20 38
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 0 00 00
# capacity, the enqueue of 2b while full is dropped
1 23 00 00 40 0 0 1 1  0 0 00  0 0 00  0 00  0  1 0 00 00
1 24 00 00 41 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 25 00 00 42 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 26 00 00 43 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 27 00 00 44 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 28 00 00 45 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 29 00 00 46 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 2a 00 00 47 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 23 40
1 2b 00 00 48 0 0 1 1  0 0 00  0 0 00  0 00  0  0 1 23 40
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  0 1 23 40
1 2c 00 00 49 0 0 1 1  0 0 00  0 0 00  0 00  0  1 1 24 41
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  0 1 24 41
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 25 42
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 26 43
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 27 44
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 28 45
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 29 46
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 2a 47
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 1 2c 49
0 00 00 00 00 0 0 0 0  0 0 00  0 0 00  0 00  1  1 0 00 00

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst
);

    // 8 ns period
    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // reset is released on the tenth rising edge
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clock);
        rst <= 1'b0;
    end

endmodule

// File: tb_int_isq.sv
`timescale 1ns/1ps

module tb_int_isq import isq_pkg::*; ();

    // one cycle of the trace with the inputs first and the expected outputs last
    typedef struct packed {
        logic                enq_valid;
        logic [ROB_ID_W-1:0] robid;
        logic [PREG_W-1:0]   prs1;
        logic [PREG_W-1:0]   prs2;
        logic [PREG_W-1:0]   prd;
        logic                src1_is_reg;
        logic                src2_is_reg;
        logic                src1_state;
        logic                src2_state;
        wb_t [WB_PORTS-1:0]  wb;
        logic                flush_valid;
        logic [ROB_ID_W-1:0] flush_robid;
        logic                issue_ready;
        logic                exp_can_alloc;
        logic                exp_issue_valid;
        logic [ROB_ID_W-1:0] exp_robid;
        logic [PREG_W-1:0]   exp_prd;
    } trace_row_t;

    logic                clock;
    logic                rst;
    logic                enq_valid;
    enq_t                enq;
    logic                iq_can_alloc;
    wb_t  [WB_PORTS-1:0] wb;
    logic                issue_valid;
    logic                issue_ready;
    uop_t                issue_uop;
    logic                flush_valid;
    logic [ROB_ID_W-1:0] flush_robid;

    trace_row_t rows[$];
    logic       trace_loaded = 1'b0;
    int         errors = 0;
    int         checks = 0;

    tb_clock_gen u_clock_gen (
        .clock (clock),
        .rst   (rst)
    );

    int_isq int_isq_i (
        .clock        (clock),
        .rst          (rst),
        .enq_valid    (enq_valid),
        .enq          (enq),
        .iq_can_alloc (iq_can_alloc),
        .wb           (wb),
        .issue_valid  (issue_valid),
        .issue_ready  (issue_ready),
        .issue_uop    (issue_uop),
        .flush_valid  (flush_valid),
        .flush_robid  (flush_robid)
    );

    // the fields the queue never looks at get filler values derived from the ids
    function automatic enq_t build_enq(input trace_row_t r);
        enq_t e;
        e                 = '0;
        e.uop.pc          = 32'h0000_1000 + 32'(r.robid) * 4;
        e.uop.instr       = 32'h0000_0013;
        e.uop.imm         = XLEN'(r.prd);
        e.uop.alu_type    = ALU_TYPE_W'(r.robid[1:0]);
        e.uop.need_to_wb  = 1'b1;
        e.uop.src1_is_reg = r.src1_is_reg;
        e.uop.src2_is_reg = r.src2_is_reg;
        e.uop.prs1        = r.prs1;
        e.uop.prs2        = r.prs2;
        e.uop.prd         = r.prd;
        e.uop.robid       = r.robid;
        e.src1_state      = r.src1_state;
        e.src2_state      = r.src2_state;
        return e;
    endfunction

    // payload of the latest earlier trace row that enqueued this id and destination
    function automatic logic find_enqueued(
        input  int         row,
        input  trace_row_t r,
        output uop_t       u
    );
        enq_t e;
        u = '0;
        for (int k = row - 1; k >= 0; k--) begin
            if (rows[k].enq_valid && rows[k].robid == r.exp_robid
                    && rows[k].prd == r.exp_prd) begin
                e = build_enq(rows[k]);
                u = e.uop;
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic load_trace();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [22];
        trace_row_t  r;
        fd = $fopen("isq_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open isq_trace.txt for reading");
            errors++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 0 && line.getc(0) != "#") begin
                n = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                    f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19],
                    f[20], f[21]);
                if (n == 22) begin
                    r.enq_valid        = f[0][0];
                    r.robid            = f[1][ROB_ID_W-1:0];
                    r.prs1             = f[2][PREG_W-1:0];
                    r.prs2             = f[3][PREG_W-1:0];
                    r.prd              = f[4][PREG_W-1:0];
                    r.src1_is_reg      = f[5][0];
                    r.src2_is_reg      = f[6][0];
                    r.src1_state       = f[7][0];
                    r.src2_state       = f[8][0];
                    r.wb[0].valid      = f[9][0];
                    r.wb[0].need_to_wb = f[10][0];
                    r.wb[0].prd        = f[11][PREG_W-1:0];
                    r.wb[1].valid      = f[12][0];
                    r.wb[1].need_to_wb = f[13][0];
                    r.wb[1].prd        = f[14][PREG_W-1:0];
                    r.flush_valid      = f[15][0];
                    r.flush_robid      = f[16][ROB_ID_W-1:0];
                    r.issue_ready      = f[17][0];
                    r.exp_can_alloc    = f[18][0];
                    r.exp_issue_valid  = f[19][0];
                    r.exp_robid        = f[20][ROB_ID_W-1:0];
                    r.exp_prd          = f[21][PREG_W-1:0];
                    rows.push_back(r);
                end else if (n > 0) begin
                    $display("malformed trace line: %s", line);
                    errors++;
                end
            end
        end
        $fclose(fd);
        if (rows.size() == 0) begin
            $display("the trace file holds no cycles");
            errors++;
        end
    endtask

    task automatic drive_inputs(input trace_row_t r);
        enq_valid   <= r.enq_valid;
        enq         <= build_enq(r);
        wb          <= r.wb;
        flush_valid <= r.flush_valid;
        flush_robid <= r.flush_robid;
        issue_ready <= r.issue_ready;
    endtask

    task automatic check_outputs(input trace_row_t r, input int cycle);
        uop_t exp_uop;
        logic found;
        checks += 2;
        assert (iq_can_alloc === r.exp_can_alloc) else begin
            $display("FAILED iq_can_alloc at cycle %0d: expected %h, got %h",
                     cycle, r.exp_can_alloc, iq_can_alloc);
            errors++;
        end
        assert (issue_valid === r.exp_issue_valid) else begin
            $display("FAILED issue_valid at cycle %0d: expected %h, got %h",
                     cycle, r.exp_issue_valid, issue_valid);
            errors++;
        end
        // the payload only matters while an issue is offered
        if (r.exp_issue_valid) begin
            checks += 3;
            assert (issue_uop.robid === r.exp_robid) else begin
                $display("FAILED issue_uop.robid at cycle %0d: expected %h, got %h",
                         cycle, r.exp_robid, issue_uop.robid);
                errors++;
            end
            assert (issue_uop.prd === r.exp_prd) else begin
                $display("FAILED issue_uop.prd at cycle %0d: expected %h, got %h",
                         cycle, r.exp_prd, issue_uop.prd);
                errors++;
            end
            // the rest of the payload has to match what was enqueued under that id
            found = find_enqueued(cycle - 1, r, exp_uop);
            assert (found) else begin
                $display("cycle %0d expects an id that no earlier trace row enqueued", cycle);
                errors++;
            end
            assert (!found || issue_uop === exp_uop) else begin
                $display("FAILED issue_uop at cycle %0d: expected %h, got %h",
                         cycle, exp_uop, issue_uop);
                errors++;
            end
        end
    endtask

    initial begin : stimulus
        enq_valid   = 1'b0;
        enq         = '0;
        wb          = '0;
        issue_ready = 1'b0;
        flush_valid = 1'b0;
        flush_robid = '0;
        load_trace();
        trace_loaded = 1'b1;
        @(negedge rst);
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clock);
            drive_inputs(rows[i]);
            // outputs are combinational, so they have settled well before the next edge
            #6;
            check_outputs(rows[i], i + 1);
        end
        $display("run finished: %0d cycles, %0d checks, %0d errors",
                 rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // reset and the trace together fit inside the trace length plus 20 cycles
    initial begin : watchdog
        wait (trace_loaded);
        #((rows.size() + 20) * 8);
        $display("timeout: the trace did not finish within %0d cycles, %0d errors so far",
                 rows.size() + 20, errors);
        $display("Test failed");
        $finish;
    end

endmodule
